/* source/aesDecPkg.sv */
package aesDecPkg;

  // Block geometry
  localparam int byteWidth = 8;
  localparam int blockWidth = 128;
  localparam int numBytes = blockWidth / byteWidth;

  // AES-128 only
  localparam int numRounds = 10;

  // Low byte of x^8 + x^4 + x^3 + x + 1
  localparam logic [7:0] gfPoly = 8'h1b;

  typedef logic [byteWidth-1:0] byteT;

  // Byte 0 is the most significant byte
  typedef logic [blockWidth-1:0] blockT;

  typedef logic [blockWidth-1:0] roundKeyT;

  // Round key i at slice i, key 0 in the low 128 bits
  typedef logic [(numRounds+1)*blockWidth-1:0] keyScheduleT;

  typedef logic [3:0] roundIdxT;

  typedef enum logic
  {
    idle,
    run
  } ctrlStateT;

  // Multiply by x in GF(2^8)
  function automatic byteT xtime(input byteT value);
    byteT shifted;
    shifted = {value[byteWidth-2:0], 1'b0};
    if (value[byteWidth-1])
    begin
      shifted = shifted ^ gfPoly;
    end
    return shifted;
  endfunction

endpackage

/* source/invSBox.sv */
`timescale 1ns/10ps

module invSBox import aesDecPkg::*;
(
  input  byteT inByte,
  output byteT outByte
);

  // FIPS-197 inverse S-box, entry 0 first, one row of 16 per line
  localparam byteT [0:255] invTable =
  {
    128'h52096ad5_3036a538_bf40a39e_81f3d7fb,
    128'h7ce33982_9b2fff87_348e4344_c4dee9cb,
    128'h547b9432_a6c2233d_ee4c950b_42fac34e,
    128'h082ea166_28d924b2_765ba249_6d8bd125,
    128'h72f8f664_86689816_d4a45ccc_5d65b692,
    128'h6c704850_fdedb9da_5e154657_a78d9d84,
    128'h90d8ab00_8cbcd30a_f7e45805_b8b34506,
    128'hd02c1e8f_ca3f0f02_c1afbd03_01138a6b,
    128'h3a911141_4f67dcea_97f2cfce_f0b4e673,
    128'h96ac7422_e7ad3585_e2f937e8_1c75df6e,
    128'h47f11a71_1d29c589_6fb7620e_aa18be1b,
    128'hfc563e4b_c6d27920_9adbc0fe_78cd5af4,
    128'h1fdda833_8807c731_b1121059_2780ec5f,
    128'h60517fa9_19b54a0d_2de57a9f_93c99cef,
    128'ha0e03b4d_ae2af5b0_c8ebbb3c_83539961,
    128'h172b047e_ba77d626_e1691463_55210c7d
  };

  assign outByte = invTable[inByte];

endmodule

/* source/invMixColumns.sv */
`timescale 1ns/10ps

module invMixColumns import aesDecPkg::*;
(
  input  blockT inBlock,
  output blockT outBlock
);

  localparam int colWidth = 4 * byteWidth;

  // Constant multiply for the 4-bit coefficients of the inverse matrix
  function automatic byteT mulConst(input byteT value, input logic [3:0] coeff);
    byteT times2;
    byteT times4;
    byteT times8;
    byteT product;
    times2 = xtime(value);
    times4 = xtime(times2);
    times8 = xtime(times4);
    product = '0;
    if (coeff[0])
      product = product ^ value;
    if (coeff[1])
      product = product ^ times2;
    if (coeff[2])
      product = product ^ times4;
    if (coeff[3])
      product = product ^ times8;
    return product;
  endfunction

  for (genvar col = 0; col < 4; col++)
  begin : gColumn
    byteT a0;
    byteT a1;
    byteT a2;
    byteT a3;

    assign {a0, a1, a2, a3} = inBlock[blockWidth-1-colWidth*col -: colWidth];

    // Rows of the matrix 0e 0b 0d 09 rotated right per output byte
    assign outBlock[blockWidth-1-colWidth*col -: colWidth] =
    {
      mulConst(a0, 4'he) ^ mulConst(a1, 4'hb) ^ mulConst(a2, 4'hd) ^ mulConst(a3, 4'h9),
      mulConst(a0, 4'h9) ^ mulConst(a1, 4'he) ^ mulConst(a2, 4'hb) ^ mulConst(a3, 4'hd),
      mulConst(a0, 4'hd) ^ mulConst(a1, 4'h9) ^ mulConst(a2, 4'he) ^ mulConst(a3, 4'hb),
      mulConst(a0, 4'hb) ^ mulConst(a1, 4'hd) ^ mulConst(a2, 4'h9) ^ mulConst(a3, 4'he)
    };
  end

endmodule

/* source/decryptDatapath.sv */
`timescale 1ns/10ps

module decryptDatapath import aesDecPkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  input  logic     load,
  input  logic     advance,
  input  logic     lastRound,
  input  blockT    cipherText,
  input  roundKeyT roundKey,
  output blockT    plainText,
  output logic     done
);

  blockT stateReg;
  blockT shifted;
  blockT subbed;
  blockT keyed;
  blockT mixed;
  blockT roundOut;

  for (genvar i = 0; i < numBytes; i++)
  begin : gByte
    // Byte i is row i%4, column i/4; each row rotates right by its index
    localparam int row = i % 4;
    localparam int srcCol = (i / 4 - row + 4) % 4;
    localparam int src = row + 4 * srcCol;

    assign shifted[blockWidth-1-byteWidth*i -: byteWidth] =
      stateReg[blockWidth-1-byteWidth*src -: byteWidth];

    invSBox invSBox_inst
    (
      .inByte  (shifted[blockWidth-1-byteWidth*i -: byteWidth]),
      .outByte (subbed[blockWidth-1-byteWidth*i -: byteWidth])
    );
  end

  assign keyed = subbed ^ roundKey;

  invMixColumns invMixColumns_inst
  (
    .inBlock  (keyed),
    .outBlock (mixed)
  );

  // Final round skips InvMixColumns
  assign roundOut = lastRound ? keyed : mixed;

  always_ff @(posedge clk)
  begin
    if (load)
      stateReg <= cipherText ^ roundKey;
    else if (advance)
      stateReg <= roundOut;
  end

  always_ff @(posedge clk)
  begin
    if (advance && lastRound)
      plainText <= roundOut;
  end

  always_ff @(posedge clk)
  begin
    if (!rstN)
      done <= 1'b0;
    else
      done <= advance && lastRound;
  end

  // A round never runs on a state that was not loaded
  assert property (@(posedge clk) disable iff (!rstN)
    advance |-> !$isunknown(stateReg));

endmodule

/* source/decryptControl.sv */
`timescale 1ns/10ps

module decryptControl import aesDecPkg::*;
(
  input  logic        clk,
  input  logic        rstN,
  input  logic        start,
  input  keyScheduleT roundKeys,
  output logic        load,
  output logic        advance,
  output logic        lastRound,
  output roundKeyT    roundKey,
  output logic        busy
);

  ctrlStateT state;
  roundIdxT  roundCnt;
  roundIdxT  keyIdx;

  assign busy = (state == run);
  assign load = !busy && start;
  assign advance = busy;
  assign lastRound = busy && (roundCnt == '0);

  // Whitening takes key 10, each round then the key of its counter value
  assign keyIdx = busy ? roundCnt : roundIdxT'(numRounds);
  assign roundKey = roundKeys[int'(keyIdx) * $bits(roundKeyT) +: $bits(roundKeyT)];

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      state <= idle;
      roundCnt <= '0;
    end
    else
    begin
      case (state)
        idle:
          if (start)
          begin
            state <= run;
            roundCnt <= roundIdxT'(numRounds - 1);
          end
        run:
          if (roundCnt == '0)
            state <= idle;
          else
            roundCnt <= roundCnt - 1'b1;
        default:
          state <= idle;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (!rstN)
    busy |-> roundCnt <= roundIdxT'(numRounds - 1));

  // A block occupies the core for exactly ten cycles after its load
  assert property (@(posedge clk) disable iff (!rstN)
    load |-> !busy ##1 busy [*numRounds] ##1 !busy);

  // Rounds only follow a load or a previous round
  assert property (@(posedge clk) disable iff (!rstN)
    advance |-> busy && $past(load || advance));

endmodule

/* source/aesDecryptTop.sv */
`timescale 1ns/10ps

module aesDecryptTop import aesDecPkg::*;
(
  input  logic        clk,
  input  logic        rstN,
  input  logic        start,
  input  blockT       cipherText,
  input  keyScheduleT roundKeys,
  output blockT       plainText,
  output logic        done,
  output logic        busy
);

  logic     load;
  logic     advance;
  logic     lastRound;
  roundKeyT roundKey;

  // Sequencing and key selection
  decryptControl decryptControl_inst
  (
    .clk       (clk),
    .rstN      (rstN),
    .start     (start),
    .roundKeys (roundKeys),
    .load      (load),
    .advance   (advance),
    .lastRound (lastRound),
    .roundKey  (roundKey),
    .busy      (busy)
  );

  // One inverse round per clock
  decryptDatapath decryptDatapath_inst
  (
    .clk        (clk),
    .rstN       (rstN),
    .load       (load),
    .advance    (advance),
    .lastRound  (lastRound),
    .cipherText (cipherText),
    .roundKey   (roundKey),
    .plainText  (plainText),
    .done       (done)
  );

endmodule

/* test/decryptChecker.sv */
`timescale 1ns/10ps

module decryptChecker import aesDecPkg::*;
(
  input  logic  clk,
  input  logic  rstN,
  input  logic  start,
  input  logic  busy,
  input  logic  done,
  input  blockT plainText,
  input  blockT expPlain,
  output int    mismatchCount,
  output int    protocolCount,
  output int    pendingCount
);

  // Sampled edges from the accepting edge to the first edge that sees done
  localparam int doneLatency = numRounds + 1;

  blockT expQ[$];
  int    acceptQ[$];
  int    cycle = 0;
  int    mismatches = 0;
  int    protocolErrors = 0;
  int    pending = 0;
  logic  prevDone = 1'b0;
  logic  prevRstLow = 1'b0;
  logic  haveResult = 1'b0;
  blockT heldPlain;

  assign mismatchCount = mismatches;
  assign protocolCount = protocolErrors;
  assign pendingCount = pending;

  always @(posedge clk)
  begin
    blockT expected;
    int    acceptCycle;
    logic  expBusy;
    cycle = cycle + 1;

    // Busy for ten cycles after the edge that accepted a start
    expBusy = (acceptQ.size() != 0) && (cycle - acceptQ[0] < doneLatency);

    // Outputs must be cleared once a reset edge has passed
    if (prevRstLow && (done !== 1'b0 || busy !== 1'b0))
    begin
      protocolErrors++;
      $display("At %0t ns done or busy was not low during or right after reset", $time);
    end

    if (rstN)
    begin
      if (busy !== expBusy)
      begin
        mismatches++;
        $display("FAILED at %0t ns: busy expected %b actual %b", $time, expBusy, busy);
      end

      if (done === 1'b1)
      begin
        if (prevDone)
        begin
          protocolErrors++;
          $display("At %0t ns done stayed high for more than one cycle", $time);
        end
        if (expQ.size() == 0)
        begin
          protocolErrors++;
          $display("At %0t ns done pulsed with no block in flight", $time);
        end
        else
        begin
          expected = expQ.pop_front();
          acceptCycle = acceptQ.pop_front();
          if (cycle - acceptCycle != doneLatency)
          begin
            protocolErrors++;
            $display("At %0t ns done came %0d cycles after start instead of %0d",
              $time, cycle - acceptCycle - 1, doneLatency - 1);
          end
          if (plainText !== expected)
          begin
            mismatches++;
            $display("FAILED at %0t ns: plainText expected %h actual %h",
              $time, expected, plainText);
          end
        end
        heldPlain = plainText;
        haveResult = 1'b1;
      end
      else if (haveResult && plainText !== heldPlain)
      begin
        // Result must hold until the next done
        mismatches++;
        $display("FAILED at %0t ns: plainText expected %h actual %h",
          $time, heldPlain, plainText);
      end

      // A start is taken only while the core is idle
      if (start === 1'b1 && !expBusy)
      begin
        expQ.push_back(expPlain);
        acceptQ.push_back(cycle);
      end
    end

    pending = expQ.size();
    prevDone = (done === 1'b1);
    prevRstLow = !rstN;
  end

endmodule

/* test/aesDecryptTb.sv */
`timescale 1ns/10ps

module aesDecryptTb import aesDecPkg::*;
();

  localparam int driveDelay = 2;
  localparam int doneTimeout = 20;
  localparam int maxGap = 5;

  logic        clk;
  logic        rstN;
  logic        start;
  blockT       cipherText;
  keyScheduleT roundKeys;
  blockT       plainText;
  logic        done;
  logic        busy;
  blockT       expPlain;

  int mismatchCount;
  int protocolCount;
  int pendingCount;
  int timeoutCount;
  int fileErrors;

  blockT       ctArr[$];
  keyScheduleT keyArr[$];
  blockT       ptArr[$];

  aesDecryptTop aesDecryptTop_inst
  (
    .clk        (clk),
    .rstN       (rstN),
    .start      (start),
    .cipherText (cipherText),
    .roundKeys  (roundKeys),
    .plainText  (plainText),
    .done       (done),
    .busy       (busy)
  );

  decryptChecker decryptChecker_inst
  (
    .clk           (clk),
    .rstN          (rstN),
    .start         (start),
    .busy          (busy),
    .done          (done),
    .plainText     (plainText),
    .expPlain      (expPlain),
    .mismatchCount (mismatchCount),
    .protocolCount (protocolCount),
    .pendingCount  (pendingCount)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Columns: ciphertext, round keys 0 to 10, expected plaintext
  task automatic readVectors();
    int       fd;
    int       fields;
    int       lineNum;
    string    line;
    blockT    ct;
    blockT    pt;
    roundKeyT rk[0:numRounds];
    keyScheduleT sched;
    lineNum = 0;
    fd = $fopen("test/aesDecryptTests.txt", "r");
    if (fd == 0)
    begin
      fileErrors++;
      $display("Could not open the test vector file");
      return;
    end
    while ($fgets(line, fd) != 0)
    begin
      lineNum++;
      if (line.len() < 32 || line.getc(0) == "#")
        continue;
      fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h", ct,
        rk[0], rk[1], rk[2], rk[3], rk[4], rk[5], rk[6], rk[7], rk[8], rk[9], rk[10], pt);
      if (fields != 13)
      begin
        fileErrors++;
        $display("Line %0d of the test vector file is malformed", lineNum);
        continue;
      end
      for (int i = 0; i <= numRounds; i++)
        sched[i*blockWidth +: blockWidth] = rk[i];
      ctArr.push_back(ct);
      keyArr.push_back(sched);
      ptArr.push_back(pt);
    end
    $fclose(fd);
    if (ctArr.size() == 0)
    begin
      fileErrors++;
      $display("No test vectors were read");
    end
  endtask

  task automatic idleCycles(input int count);
    repeat (count)
    begin
      @(posedge clk);
      #driveDelay;
    end
  endtask

  // Holds start for one edge; keys stay on the bus until the next block
  task automatic issueBlock(input int idx);
    cipherText = ctArr[idx];
    roundKeys = keyArr[idx];
    expPlain = ptArr[idx];
    start = 1'b1;
    @(posedge clk);
    #driveDelay;
    start = 1'b0;
  endtask

  task automatic waitForDone();
    int  cycles;
    logic seen;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < doneTimeout)
    begin
      @(posedge clk);
      #driveDelay;
      cycles++;
      if (done === 1'b1)
        seen = 1'b1;
    end
    if (!seen)
    begin
      timeoutCount++;
      $display("At %0t ns no done arrived within %0d cycles", $time, doneTimeout);
    end
  endtask

  initial
  begin
    int gap;
    int totalErrors;
    rstN = 1'b0;
    start = 1'b0;
    cipherText = '0;
    roundKeys = '0;
    expPlain = '0;
    timeoutCount = 0;
    fileErrors = 0;
    void'($urandom(87));

    readVectors();

    repeat (4) @(posedge clk);
    #driveDelay;
    rstN = 1'b1;

    // Quiet period, no done may appear
    idleCycles(6);

    // All vectors with random idle gaps, C.1 first
    for (int i = 0; i < ctArr.size(); i++)
    begin
      issueBlock(i);
      waitForDone();
      gap = int'($urandom_range(maxGap, 0));
      idleCycles(gap);
    end

    // Next start presented in the same cycle as done
    for (int i = 0; i < ctArr.size(); i++)
    begin
      issueBlock(i);
      waitForDone();
    end
    idleCycles(2);

    // Second start while busy carries other data and must be dropped
    if (ctArr.size() >= 2)
    begin
      issueBlock(0);
      idleCycles(3);
      cipherText = ctArr[1];
      expPlain = ptArr[1];
      start = 1'b1;
      idleCycles(1);
      start = 1'b0;
      waitForDone();
      idleCycles(15);
    end

    idleCycles(3);
    totalErrors = mismatchCount + protocolCount + timeoutCount + fileErrors + pendingCount;
    $display("Errors: %0d mismatches, %0d protocol, %0d timeouts, %0d file, %0d unfinished",
      mismatchCount, protocolCount, timeoutCount, fileErrors, pendingCount);
    if (totalErrors == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

/* test/aesDecryptTests.txt */
# One vector per line, hex: ciphertext, round key 0 .. round key 10, expected plaintext
# Vectors: FIPS-197 C.1, FIPS-197 B, SP 800-38A ECB blocks 1 to 4, all-zero key
69c4e0d86a7b0430d8cdb78070b4c55a 000102030405060708090a0b0c0d0e0f d6aa74fdd2af72fadaa678f1d6ab76fe b692cf0b643dbdf1be9bc5006830b3fe b6ff744ed2c2c9bf6c590cbf0469bf41 47f7f7bc95353e03f96c32bcfd058dfd 3caaa3e8a99f9deb50f3af57adf622aa 5e390f7df7a69296a7553dc10aa31f6b 14f9701ae35fe28c440adf4d4ea9c026 47438735a41c65b9e016baf4aebf7ad2 549932d1f08557681093ed9cbe2c974e 13111d7fe3944a17f307a78b4d2b30c5 00112233445566778899aabbccddeeff
3925841d02dc09fbdc118597196a0b32 2b7e151628aed2a6abf7158809cf4f3c a0fafe1788542cb123a339392a6c7605 f2c295f27a96b9435935807a7359f67f 3d80477d4716fe3e1e237e446d7a883b ef44a541a8525b7fb671253bdb0bad00 d4d1c6f87c839d87caf2b8bc11f915bc 6d88a37a110b3efddbf98641ca0093fd 4e54f70e5f5fc9f384a64fb24ea6dc4f ead27321b58dbad2312bf5607f8d292f ac7766f319fadc2128d12941575c006e d014f9a8c9ee2589e13f0cc8b6630ca6 3243f6a8885a308d313198a2e0370734
3ad77bb40d7a3660a89ecaf32466ef97 2b7e151628aed2a6abf7158809cf4f3c a0fafe1788542cb123a339392a6c7605 f2c295f27a96b9435935807a7359f67f 3d80477d4716fe3e1e237e446d7a883b ef44a541a8525b7fb671253bdb0bad00 d4d1c6f87c839d87caf2b8bc11f915bc 6d88a37a110b3efddbf98641ca0093fd 4e54f70e5f5fc9f384a64fb24ea6dc4f ead27321b58dbad2312bf5607f8d292f ac7766f319fadc2128d12941575c006e d014f9a8c9ee2589e13f0cc8b6630ca6 6bc1bee22e409f96e93d7e117393172a
f5d3d58503b9699de785895a96fdbaaf 2b7e151628aed2a6abf7158809cf4f3c a0fafe1788542cb123a339392a6c7605 f2c295f27a96b9435935807a7359f67f 3d80477d4716fe3e1e237e446d7a883b ef44a541a8525b7fb671253bdb0bad00 d4d1c6f87c839d87caf2b8bc11f915bc 6d88a37a110b3efddbf98641ca0093fd 4e54f70e5f5fc9f384a64fb24ea6dc4f ead27321b58dbad2312bf5607f8d292f ac7766f319fadc2128d12941575c006e d014f9a8c9ee2589e13f0cc8b6630ca6 ae2d8a571e03ac9c9eb76fac45af8e51
43b1cd7f598ece23881b00e3ed030688 2b7e151628aed2a6abf7158809cf4f3c a0fafe1788542cb123a339392a6c7605 f2c295f27a96b9435935807a7359f67f 3d80477d4716fe3e1e237e446d7a883b ef44a541a8525b7fb671253bdb0bad00 d4d1c6f87c839d87caf2b8bc11f915bc 6d88a37a110b3efddbf98641ca0093fd 4e54f70e5f5fc9f384a64fb24ea6dc4f ead27321b58dbad2312bf5607f8d292f ac7766f319fadc2128d12941575c006e d014f9a8c9ee2589e13f0cc8b6630ca6 30c81c46a35ce411e5fbc1191a0a52ef
7b0c785e27e8ad3f8223207104725dd4 2b7e151628aed2a6abf7158809cf4f3c a0fafe1788542cb123a339392a6c7605 f2c295f27a96b9435935807a7359f67f 3d80477d4716fe3e1e237e446d7a883b ef44a541a8525b7fb671253bdb0bad00 d4d1c6f87c839d87caf2b8bc11f915bc 6d88a37a110b3efddbf98641ca0093fd 4e54f70e5f5fc9f384a64fb24ea6dc4f ead27321b58dbad2312bf5607f8d292f ac7766f319fadc2128d12941575c006e d014f9a8c9ee2589e13f0cc8b6630ca6 f69f2445df4f9b17ad2b417be66c3710
66e94bd4ef8a2c3b884cfa59ca342b2e 00000000000000000000000000000000 62636363626363636263636362636363 9b9898c9f9fbfbaa9b9898c9f9fbfbaa 90973450696ccffaf2f457330b0fac99 ee06da7b876a1581759e42b27e91ee2b 7f2e2b88f8443e098dda7cbbf34b9290 ec614b851425758c99ff09376ab49ba7 217517873550620bacaf6b3cc61bf09b 0ef903333ba9613897060a04511dfa9f b1d4d8e28a7db9da1d7bb3de4c664941 b4ef5bcb3e92e21123e951cf6f8f188e 00000000000000000000000000000000

/* tb.f */
source/aesDecPkg.sv
source/invSBox.sv
source/invMixColumns.sv
source/decryptDatapath.sv
source/decryptControl.sv
source/aesDecryptTop.sv
test/decryptChecker.sv
test/aesDecryptTb.sv

/* Makefile */
# Verilator build for the AES-128 decryption core testbench

VERILATOR ?= verilator
TOP       ?= aesDecryptTb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY  := $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# The log decides the result, the simulator exit status is not used
run: compile
	-./$(BINARY) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "TESTS PASSED" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)
